// ==== src/coh_pkg.sv ====
`default_nettype none

package coh_pkg;

	// Data path and address widths
	localparam int WORD_W = 32;
	localparam int ADDR_W = 32;

	// Byte address fields
	localparam int INDEX_LSB = 2;
	localparam int INDEX_W   = 3;
	localparam int TAG_LSB   = INDEX_LSB + INDEX_W;
	localparam int TAG_W     = ADDR_W - TAG_LSB;
	localparam int MEM_LSB   = 2;
	localparam int MEM_W     = 6;

	// Block sizes
	localparam int NUM_PROCS = 3;
	localparam int NUM_LINES = 1 << INDEX_W;
	localparam int MEM_WORDS = 1 << MEM_W;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [INDEX_W-1:0]   index_t;
	typedef logic [TAG_W-1:0]     tag_t;
	typedef logic [MEM_W-1:0]     mem_addr_t;
	typedef logic [1:0]           proc_id_t;
	typedef logic [NUM_PROCS-1:0] proc_mask_t;

	// 2'b11 marks a dirty line
	typedef enum logic [1:0] {
		MESI_I = 2'b00,
		MESI_S = 2'b01,
		MESI_E = 2'b10,
		MESI_M = 2'b11
	} mesi_t;

	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_SNOOP,
		BUS_FILL
	} bus_state_t;

	function automatic index_t addr_index(addr_t a);
		return a[TAG_LSB-1:INDEX_LSB];
	endfunction

	function automatic tag_t addr_tag(addr_t a);
		return a[ADDR_W-1:TAG_LSB];
	endfunction

	// Memory aliases addresses that share these bits
	function automatic mem_addr_t addr_mem(addr_t a);
		return a[MEM_LSB+MEM_W-1:MEM_LSB];
	endfunction

endpackage

`default_nettype wire

// ==== src/cache_port_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface cache_port_if
	import coh_pkg::*;
();

	// Driven by the coherence bus
	logic   req_valid;
	logic   snoop_valid;
	logic   snoop_excl;
	addr_t  addr;
	logic   fill_valid;
	mesi_t  fill_state;
	word_t  fill_data;

	// Lookup results from the cache
	logic   own_hit;
	mesi_t  own_state;
	word_t  own_data;
	logic   victim_dirty;
	addr_t  victim_addr;

	// Snoop answer
	logic   snoop_hit;
	logic   snoop_dirty;
	word_t  snoop_data;

	modport bus (
		output req_valid, snoop_valid, snoop_excl, addr,
		output fill_valid, fill_state, fill_data,
		input  own_hit, own_state, own_data, victim_dirty, victim_addr,
		input  snoop_hit, snoop_dirty, snoop_data
	);

	modport cache (
		input  req_valid, snoop_valid, snoop_excl, addr,
		input  fill_valid, fill_state, fill_data,
		output own_hit, own_state, own_data, victim_dirty, victim_addr,
		output snoop_hit, snoop_dirty, snoop_data
	);

endinterface

`default_nettype wire

// ==== src/data_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_cache
	import coh_pkg::*;
(
	input wire          clk,
	input wire          reset_i,
	cache_port_if.cache port
);

	// Line storage
	tag_t   tag_q   [NUM_LINES];
	mesi_t  state_q [NUM_LINES];
	word_t  data_q  [NUM_LINES];

	index_t idx;
	tag_t   tag;
	tag_t   line_tag;
	mesi_t  line_state;
	word_t  line_data;
	logic   line_valid;
	logic   tag_match;

	// Address split of the current bus address
	assign idx = addr_index(port.addr);
	assign tag = addr_tag(port.addr);

	assign line_tag   = tag_q[idx];
	assign line_state = state_q[idx];
	assign line_data  = data_q[idx];
	assign line_valid = (line_state != MESI_I);
	assign tag_match  = line_valid && (line_tag == tag);

	// Requester lookup gated by req_valid
	assign port.own_hit   = port.req_valid && tag_match;
	assign port.own_state = port.own_hit ? line_state : MESI_I;

	// Indexed word doubles as the victim's word on a tag mismatch
	assign port.own_data = line_data;

	// Dirty line in the way of the requested tag
	assign port.victim_dirty = port.req_valid && (line_state == MESI_M) &&
		(line_tag != tag);
	assign port.victim_addr = {line_tag, idx, 2'b00};

	// Snoop answer
	assign port.snoop_hit   = tag_match;
	assign port.snoop_dirty = tag_match && (line_state == MESI_M);
	assign port.snoop_data  = line_data;

	// MESI state per line
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_LINES; i++) begin
				state_q[i] <= MESI_I;
			end
		end else if (port.fill_valid) begin
			state_q[idx] <= port.fill_state;
		end else if (port.snoop_valid && tag_match) begin
			// Exclusive snoop invalidates and plain snoop demotes to shared
			state_q[idx] <= port.snoop_excl ? MESI_I : MESI_S;
		end
	end

	// Tag and data written only by a fill
	always_ff @(posedge clk) begin
		if (port.fill_valid) begin
			tag_q[idx]  <= tag;
			data_q[idx] <= port.fill_data;
		end
	end

	// The bus never fills a cache it is snooping
	a_fill_not_snoop : assert property (
		@(posedge clk) disable iff (reset_i)
		!(port.fill_valid && port.snoop_valid)
	);

endmodule

`default_nettype wire

// ==== src/coherence_bus.sv ====
`timescale 1ns/10ps
`default_nettype none

module coherence_bus
	import coh_pkg::*;
(
	input wire             clk,
	input wire             reset_i,
	input wire             cmd_valid_i,
	input wire proc_id_t   cmd_proc_i,
	input wire             cmd_write_i,
	input wire addr_t      cmd_addr_i,
	input wire word_t      cmd_data_i,
	output logic           busy_o,
	output logic           rsp_valid_o,
	output logic           rsp_hit_o,
	output word_t          rsp_data_o,
	output mesi_t          rsp_state_o,
	output proc_mask_t     hit_bus_o,
	cache_port_if.bus      port0_o,
	cache_port_if.bus      port1_o,
	cache_port_if.bus      port2_o,
	output mem_addr_t      mem_raddr_o,
	input wire word_t      mem_rdata_i,
	output logic           mem_wa_en_o,
	output mem_addr_t      mem_wa_addr_o,
	output word_t          mem_wa_data_o,
	output logic           mem_wb_en_o,
	output mem_addr_t      mem_wb_addr_o,
	output word_t          mem_wb_data_o
);

	bus_state_t state_q;
	proc_id_t   cmd_proc_q;
	logic       cmd_write_q;
	addr_t      cmd_addr_q;
	word_t      cmd_data_q;

	// Per-cache answers gathered from the three ports
	proc_mask_t own_hit;
	proc_mask_t victim_dirty;
	proc_mask_t snoop_hit;
	proc_mask_t snoop_dirty;
	mesi_t      own_state   [NUM_PROCS];
	word_t      own_data    [NUM_PROCS];
	addr_t      victim_addr [NUM_PROCS];
	word_t      snoop_data  [NUM_PROCS];

	logic       in_snoop;
	logic       in_fill;
	logic       req_hit;
	mesi_t      req_state;
	logic       need_snoop;
	proc_mask_t req_mask;
	proc_mask_t snoop_mask;
	proc_mask_t hit_mask;
	proc_mask_t dirty_mask;
	word_t      owner_data;

	// Captured at the end of the snoop cycle
	logic       req_hit_q;
	mesi_t      req_state_q;
	word_t      req_data_q;
	proc_mask_t hit_mask_q;
	logic       owner_dirty_q;
	word_t      owner_data_q;

	word_t      fill_base;
	word_t      fill_data;
	mesi_t      fill_state;

	assign own_hit      = {port2_o.own_hit, port1_o.own_hit, port0_o.own_hit};
	assign victim_dirty = {port2_o.victim_dirty, port1_o.victim_dirty, port0_o.victim_dirty};
	assign snoop_hit    = {port2_o.snoop_hit, port1_o.snoop_hit, port0_o.snoop_hit};
	assign snoop_dirty  = {port2_o.snoop_dirty, port1_o.snoop_dirty, port0_o.snoop_dirty};

	assign own_state[0]   = port0_o.own_state;
	assign own_state[1]   = port1_o.own_state;
	assign own_state[2]   = port2_o.own_state;
	assign own_data[0]    = port0_o.own_data;
	assign own_data[1]    = port1_o.own_data;
	assign own_data[2]    = port2_o.own_data;
	assign victim_addr[0] = port0_o.victim_addr;
	assign victim_addr[1] = port1_o.victim_addr;
	assign victim_addr[2] = port2_o.victim_addr;
	assign snoop_data[0]  = port0_o.snoop_data;
	assign snoop_data[1]  = port1_o.snoop_data;
	assign snoop_data[2]  = port2_o.snoop_data;

	assign in_snoop = (state_q == BUS_SNOOP);
	assign in_fill  = (state_q == BUS_FILL);
	assign busy_o   = (state_q != BUS_IDLE);

	assign req_mask  = proc_mask_t'(3'b001 << cmd_proc_q);
	assign req_hit   = own_hit[cmd_proc_q];
	assign req_state = own_state[cmd_proc_q];

	// Read hits and writes to M or E stay local
	assign need_snoop = !req_hit || (cmd_write_q && (req_state == MESI_S));
	assign snoop_mask = need_snoop ? ~req_mask : '0;
	assign hit_mask   = snoop_hit & snoop_mask;
	assign dirty_mask = snoop_dirty & snoop_mask;

	always_comb begin
		owner_data = '0;
		for (int p = 0; p < NUM_PROCS; p++) begin
			if (dirty_mask[p]) begin
				owner_data = snoop_data[p];
			end
		end
	end

	// Data source priority is owner, own line, then memory
	always_comb begin
		if (owner_dirty_q) begin
			fill_base = owner_data_q;
		end else if (req_hit_q) begin
			fill_base = req_data_q;
		end else begin
			fill_base = mem_rdata_i;
		end
		fill_data = cmd_write_q ? cmd_data_q : fill_base;

		if (cmd_write_q) begin
			fill_state = MESI_M;
		end else if (req_hit_q) begin
			fill_state = req_state_q;
		end else if (|hit_mask_q) begin
			fill_state = MESI_S;
		end else begin
			fill_state = MESI_E;
		end
	end

	// Sequencer
	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q     <= BUS_IDLE;
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= in_fill;
			case (state_q)
				BUS_IDLE: begin
					if (cmd_valid_i) begin
						state_q <= BUS_SNOOP;
					end
				end
				BUS_SNOOP: state_q <= BUS_FILL;
				default:   state_q <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == BUS_IDLE) && cmd_valid_i) begin
			cmd_proc_q  <= cmd_proc_i;
			cmd_write_q <= cmd_write_i;
			cmd_addr_q  <= cmd_addr_i;
			cmd_data_q  <= cmd_data_i;
		end
		if (in_snoop) begin
			req_hit_q     <= req_hit;
			req_state_q   <= req_state;
			req_data_q    <= own_data[cmd_proc_q];
			hit_mask_q    <= hit_mask;
			owner_dirty_q <= |dirty_mask;
			owner_data_q  <= owner_data;
		end
		if (in_fill) begin
			rsp_hit_o   <= req_hit_q;
			rsp_data_o  <= fill_data;
			rsp_state_o <= fill_state;
			hit_bus_o   <= hit_mask_q;
		end
	end

	// Cache port drive
	assign port0_o.req_valid   = in_snoop && req_mask[0];
	assign port0_o.snoop_valid = in_snoop && snoop_mask[0];
	assign port0_o.snoop_excl  = cmd_write_q;
	assign port0_o.addr        = cmd_addr_q;
	assign port0_o.fill_valid  = in_fill && req_mask[0];
	assign port0_o.fill_state  = fill_state;
	assign port0_o.fill_data   = fill_data;

	assign port1_o.req_valid   = in_snoop && req_mask[1];
	assign port1_o.snoop_valid = in_snoop && snoop_mask[1];
	assign port1_o.snoop_excl  = cmd_write_q;
	assign port1_o.addr        = cmd_addr_q;
	assign port1_o.fill_valid  = in_fill && req_mask[1];
	assign port1_o.fill_state  = fill_state;
	assign port1_o.fill_data   = fill_data;

	assign port2_o.req_valid   = in_snoop && req_mask[2];
	assign port2_o.snoop_valid = in_snoop && snoop_mask[2];
	assign port2_o.snoop_excl  = cmd_write_q;
	assign port2_o.addr        = cmd_addr_q;
	assign port2_o.fill_valid  = in_fill && req_mask[2];
	assign port2_o.fill_state  = fill_state;
	assign port2_o.fill_data   = fill_data;

	// Memory read and victim write in the snoop cycle
	// Owner write on port B in the fill cycle
	assign mem_raddr_o   = addr_mem(cmd_addr_q);
	assign mem_wa_en_o   = in_snoop && victim_dirty[cmd_proc_q];
	assign mem_wa_addr_o = addr_mem(victim_addr[cmd_proc_q]);
	assign mem_wa_data_o = own_data[cmd_proc_q];
	assign mem_wb_en_o   = in_fill && owner_dirty_q;
	assign mem_wb_addr_o = addr_mem(cmd_addr_q);
	assign mem_wb_data_o = owner_data_q;

	a_no_cmd_when_busy : assert property (
		@(posedge clk) disable iff (reset_i)
		busy_o |-> !cmd_valid_i
	);

	a_single_owner : assert property (
		@(posedge clk) disable iff (reset_i)
		in_snoop |-> $onehot0(dirty_mask)
	);

	// A Modified requester is the only holder of its line
	a_modified_exclusive : assert property (
		@(posedge clk) disable iff (reset_i)
		(in_snoop && (req_state == MESI_M)) |-> ((snoop_hit & ~req_mask) == '0)
	);

endmodule

`default_nettype wire

// ==== src/main_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module main_memory
	import coh_pkg::*;
(
	input wire            clk,
	input wire            reset_i,
	input wire mem_addr_t raddr_i,
	output word_t         rdata_o,
	input wire            wa_en_i,
	input wire mem_addr_t wa_addr_i,
	input wire word_t     wa_data_i,
	input wire            wb_en_i,
	input wire mem_addr_t wb_addr_i,
	input wire word_t     wb_data_i
);

	word_t mem_q [MEM_WORDS];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem_q[i] <= '0;
			end
			rdata_o <= '0;
		end else begin
			if (wa_en_i) begin
				mem_q[wa_addr_i] <= wa_data_i;
			end
			if (wb_en_i) begin
				mem_q[wb_addr_i] <= wb_data_i;
			end
			// A read sees a word written on the same edge
			if (wb_en_i && (wb_addr_i == raddr_i)) begin
				rdata_o <= wb_data_i;
			end else if (wa_en_i && (wa_addr_i == raddr_i)) begin
				rdata_o <= wa_data_i;
			end else begin
				rdata_o <= mem_q[raddr_i];
			end
		end
	end

	// Victim and owner writebacks target different words
	a_write_ports_disjoint : assert property (
		@(posedge clk) disable iff (reset_i)
		!(wa_en_i && wb_en_i && (wa_addr_i == wb_addr_i))
	);

endmodule

`default_nettype wire

// ==== src/processor_block.sv ====
`timescale 1ns/10ps
`default_nettype none

module processor_block
	import coh_pkg::*;
(
	input wire           clk,
	input wire           reset_i,
	input wire           cmd_valid_i,
	input wire proc_id_t cmd_proc_i,
	input wire           cmd_write_i,
	input wire addr_t    cmd_addr_i,
	input wire word_t    cmd_data_i,
	output logic         busy_o,
	output logic         rsp_valid_o,
	output logic         rsp_hit_o,
	output word_t        rsp_data_o,
	output mesi_t        rsp_state_o,
	output proc_mask_t   hit_bus_o
);

	// Memory side of the bus
	mem_addr_t mem_raddr;
	word_t     mem_rdata;
	logic      mem_wa_en;
	mem_addr_t mem_wa_addr;
	word_t     mem_wa_data;
	logic      mem_wb_en;
	mem_addr_t mem_wb_addr;
	word_t     mem_wb_data;

	cache_port_if port0 ();
	cache_port_if port1 ();
	cache_port_if port2 ();

	data_cache u_cache0 (
		.clk     (clk),
		.reset_i (reset_i),
		.port    (port0.cache)
	);

	data_cache u_cache1 (
		.clk     (clk),
		.reset_i (reset_i),
		.port    (port1.cache)
	);

	data_cache u_cache2 (
		.clk     (clk),
		.reset_i (reset_i),
		.port    (port2.cache)
	);

	coherence_bus u_bus (
		.clk           (clk),
		.reset_i       (reset_i),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_proc_i    (cmd_proc_i),
		.cmd_write_i   (cmd_write_i),
		.cmd_addr_i    (cmd_addr_i),
		.cmd_data_i    (cmd_data_i),
		.busy_o        (busy_o),
		.rsp_valid_o   (rsp_valid_o),
		.rsp_hit_o     (rsp_hit_o),
		.rsp_data_o    (rsp_data_o),
		.rsp_state_o   (rsp_state_o),
		.hit_bus_o     (hit_bus_o),
		.port0_o       (port0.bus),
		.port1_o       (port1.bus),
		.port2_o       (port2.bus),
		.mem_raddr_o   (mem_raddr),
		.mem_rdata_i   (mem_rdata),
		.mem_wa_en_o   (mem_wa_en),
		.mem_wa_addr_o (mem_wa_addr),
		.mem_wa_data_o (mem_wa_data),
		.mem_wb_en_o   (mem_wb_en),
		.mem_wb_addr_o (mem_wb_addr),
		.mem_wb_data_o (mem_wb_data)
	);

	main_memory u_mem (
		.clk       (clk),
		.reset_i   (reset_i),
		.raddr_i   (mem_raddr),
		.rdata_o   (mem_rdata),
		.wa_en_i   (mem_wa_en),
		.wa_addr_i (mem_wa_addr),
		.wa_data_i (mem_wa_data),
		.wb_en_i   (mem_wb_en),
		.wb_addr_i (mem_wb_addr),
		.wb_data_i (mem_wb_data)
	);

endmodule

`default_nettype wire

// ==== sim/processor_block_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module processor_block_tb
	import coh_pkg::*;
();

	localparam int RSP_TIMEOUT  = 20;
	localparam int IDLE_TIMEOUT = 20;

	logic       clk;
	logic       reset_i;
	logic       cmd_valid_i;
	proc_id_t   cmd_proc_i;
	logic       cmd_write_i;
	addr_t      cmd_addr_i;
	word_t      cmd_data_i;
	logic       busy_o;
	logic       rsp_valid_o;
	logic       rsp_hit_o;
	word_t      rsp_data_o;
	mesi_t      rsp_state_o;
	proc_mask_t hit_bus_o;

	int    errors;
	int    timeouts;
	int    cases_run;
	string case_name;

	processor_block u_dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_proc_i  (cmd_proc_i),
		.cmd_write_i (cmd_write_i),
		.cmd_addr_i  (cmd_addr_i),
		.cmd_data_i  (cmd_data_i),
		.busy_o      (busy_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_hit_o   (rsp_hit_o),
		.rsp_data_o  (rsp_data_o),
		.rsp_state_o (rsp_state_o),
		.hit_bus_o   (hit_bus_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(input string field, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				case_name, field, expected, actual);
		end
	endtask

	// Letter from the case file to MESI state
	function automatic mesi_t state_from_letter(string s);
		case (s)
			"M": return MESI_M;
			"E": return MESI_E;
			"S": return MESI_S;
			default: return MESI_I;
		endcase
	endfunction

	// Drives one command, checks its response and waits for idle
	// ok drops to 0 on a timeout
	task automatic run_command(input proc_id_t proc, input logic write, input addr_t addr,
		input word_t data, input word_t exp_data, input logic exp_hit,
		input mesi_t exp_state, input proc_mask_t exp_bus, output bit ok);
		int cycles;
		ok = 1'b1;
		@(posedge clk);
		#1;
		cmd_valid_i = 1'b1;
		cmd_proc_i  = proc;
		cmd_write_i = write;
		cmd_addr_i  = addr;
		cmd_data_i  = data;
		// Edge 0 samples the command
		@(posedge clk);
		#1;
		cmd_valid_i = 1'b0;
		check_value("busy", 1, busy_o);
		cycles = 0;
		while (!rsp_valid_o && cycles < RSP_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!rsp_valid_o) begin
			$display("Timeout: no response for case %s", case_name);
			timeouts++;
			ok = 1'b0;
			return;
		end
		check_value("latency", 2, cycles);
		check_value("busy_end", 0, busy_o);
		check_value("data", exp_data, rsp_data_o);
		check_value("hit", exp_hit, rsp_hit_o);
		check_value("state", exp_state, rsp_state_o);
		check_value("hit_bus", exp_bus, hit_bus_o);
		cycles = 0;
		while (busy_o && cycles < IDLE_TIMEOUT) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (busy_o) begin
			$display("Timeout: block stayed busy after case %s", case_name);
			timeouts++;
			ok = 1'b0;
		end
	endtask

	initial begin
		int         fd;
		int         n;
		bit         ok;
		bit         aborted;
		string      line;
		string      op;
		string      st;
		int         proc;
		int         hit;
		addr_t      addr;
		word_t      data;
		word_t      exp_data;
		proc_mask_t exp_bus;

		errors      = 0;
		timeouts    = 0;
		cases_run   = 0;
		aborted     = 1'b0;
		case_name   = "reset";
		reset_i     = 1'b1;
		cmd_valid_i = 1'b0;
		cmd_proc_i  = '0;
		cmd_write_i = 1'b0;
		cmd_addr_i  = '0;
		cmd_data_i  = '0;

		repeat (4) @(posedge clk);
		#1;
		reset_i = 1'b0;
		check_value("busy", 0, busy_o);
		check_value("rsp_valid", 0, rsp_valid_o);

		fd = $fopen("sim/coherence_cases.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the case file sim/coherence_cases.txt");
			errors++;
			aborted = 1'b1;
		end
		while (!aborted && $fgets(line, fd) != 0) begin
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
				continue;
			end
			n = $sscanf(line, "%s %d %s %h %h %h %d %s %b", case_name, proc, op,
				addr, data, exp_data, hit, st, exp_bus);
			if (n != 9) begin
				$display("Malformed line in the case file: %s", line);
				errors++;
				continue;
			end
			run_command(proc_id_t'(proc), (op == "W"), addr, data, exp_data, hit[0],
				state_from_letter(st), exp_bus, ok);
			cases_run++;
			if (!ok) begin
				aborted = 1'b1;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("Cases run: %0d, failed checks: %0d, timeouts: %0d",
			cases_run, errors, timeouts);
		if (errors == 0 && timeouts == 0 && cases_run > 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/coherence_cases.txt ====
# name proc op(R/W) addr(hex) data(hex) exp_data(hex) exp_hit exp_state(I/S/E/M) exp_hit_bus(bin)
# Commands run in order, each one sees the cache state left by the ones before
cold_read_p0      0 R 00000010 00000000 00000000 0 E 000
reread_hit_e      0 R 00000010 00000000 00000000 1 E 000
write_e_to_m      0 W 00000010 11112222 11112222 1 M 000
read_from_owner   1 R 00000010 00000000 11112222 0 S 001
sharer_read_hit   0 R 00000010 00000000 11112222 1 S 000
write_invalidate  1 W 00000010 33334444 33334444 1 M 001
read_after_inval  0 R 00000010 00000000 33334444 0 S 010
write_miss_cold   2 W 00000020 aaaa0001 aaaa0001 0 M 000
write_miss_dirty  0 W 00000020 bbbb0002 bbbb0002 0 M 100
third_read_owner  1 R 00000020 00000000 bbbb0002 0 S 001
third_read_mem    2 R 00000020 00000000 bbbb0002 0 S 011
victim_setup      1 W 0000000c cafe0005 cafe0005 0 M 000
victim_alias_rd   1 R 0000010c 00000000 cafe0005 0 E 000
alias_orig_rd     0 R 0000000c 00000000 cafe0005 0 E 000
alias_share_rd    2 R 0000010c 00000000 cafe0005 0 S 010
alias_upgrade     1 W 0000010c 0bad0006 0bad0006 1 M 100
alias_owner_rd    2 R 0000010c 00000000 0bad0006 0 S 010

// ==== list.f ====
src/coh_pkg.sv
src/cache_port_if.sv
src/data_cache.sv
src/coherence_bus.sv
src/main_memory.sv
src/processor_block.sv
sim/processor_block_tb.sv
